// File: design/opq_elem_pkg.sv
//////////////////////////////////////////////////////////////////////
// Element encoding for the operand queue. Data words are fixed at 64 bits
// and elements sit contiguously, with the lowest index in the lowest bits
//////////////////////////////////////////////////////////////////////
package opq_elem_pkg;

  // Operand word as delivered by the register file
  localparam int unsigned word_width = 64;

  typedef logic [word_width-1:0] word_t;

  // Element width, encoded as log2 of the byte width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Integer widening opcodes
  typedef enum logic [2:0] {
    CONV_NONE,
    CONV_SEXT2,
    CONV_SEXT4,
    CONV_SEXT8,
    CONV_ZEXT2,
    CONV_ZEXT4,
    CONV_ZEXT8
  } conv_e;

  // log2 of the extension factor k
  function automatic logic [1:0] conv_log2_factor(conv_e conv);
    case (conv)
      CONV_SEXT2, CONV_ZEXT2: return 2'd1;
      CONV_SEXT4, CONV_ZEXT4: return 2'd2;
      CONV_SEXT8, CONV_ZEXT8: return 2'd3;
      default:                return 2'd0;
    endcase
  endfunction

  function automatic logic conv_is_sext(conv_e conv);
    return conv inside {CONV_SEXT2, CONV_SEXT4, CONV_SEXT8};
  endfunction

endpackage

// File: design/opq_cmd_pkg.sv
//////////////////////////////////////////////////////////////////////
// Queue command fields and default buffer depths. A command counts
// source elements and must never carry a count of zero
//////////////////////////////////////////////////////////////////////
package opq_cmd_pkg;

  ////////////////////////////////////////////////////////////////////
  // Element counting
  ////////////////////////////////////////////////////////////////////

  // Width of the per-command source element count
  localparam int unsigned elem_count_width = 16;

  // Number of source elements covered by one command
  typedef logic [elem_count_width-1:0] elem_count_t;

  ////////////////////////////////////////////////////////////////////
  // Buffer sizing
  ////////////////////////////////////////////////////////////////////

  // Command FIFO entries
  localparam int unsigned default_cmd_depth = 2;

  // Operand FIFO entries, which is also the number of credits
  localparam int unsigned default_data_depth = 2;

endpackage

// File: design/opq_cmd_buffer.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Commands with eew*k above 64 bits are illegal and must not be sent.
// The head is decoded combinationally from the registered slot
//////////////////////////////////////////////////////////////////////
module opq_cmd_buffer
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
#(
  parameter int unsigned CmdBufDepth = default_cmd_depth
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Command input
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  eew_e        cmd_eew_i,
  input  conv_e       cmd_conv_i,
  input  elem_count_t cmd_elem_count_i,
  // Decoded head command
  input  logic        cmd_pop_i,
  output logic        head_valid_o,
  output eew_e        head_eew_o,
  output logic        head_sign_o,
  output logic [1:0]  head_slice_shift_o,
  output logic [7:0]  head_beat_elems_o,
  output elem_count_t head_elem_count_o
);

  localparam int unsigned IdxWidth = (CmdBufDepth > 1) ? $clog2(CmdBufDepth) : 1;

  eew_e        eew_mem   [CmdBufDepth];
  conv_e       conv_mem  [CmdBufDepth];
  elem_count_t count_mem [CmdBufDepth];

  logic [IdxWidth-1:0] wr_ptr_q;
  logic [IdxWidth-1:0] rd_ptr_q;
  logic [IdxWidth:0]   fill_q;
  logic                push;
  logic                pop;
  conv_e               head_conv;
  logic [1:0]          head_shift;
  logic [2:0]          head_width_log2;

  function automatic logic [IdxWidth-1:0] ptr_inc(logic [IdxWidth-1:0] ptr);
    return (ptr == IdxWidth'(CmdBufDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign cmd_ready_o  = (fill_q < CmdBufDepth);
  assign head_valid_o = (fill_q != '0);
  assign push         = cmd_valid_i && cmd_ready_o;
  assign pop          = cmd_pop_i && head_valid_o;

  // Command storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      eew_mem[wr_ptr_q]   <= cmd_eew_i;
      conv_mem[wr_ptr_q]  <= cmd_conv_i;
      count_mem[wr_ptr_q] <= cmd_elem_count_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Head decode
  //////////////////////////////////////////////////////////////////////

  assign head_conv         = conv_mem[rd_ptr_q];
  assign head_shift        = conv_log2_factor(head_conv);
  assign head_width_log2   = {1'b0, head_eew_o} + {1'b0, head_shift};
  assign head_eew_o        = eew_mem[rd_ptr_q];
  assign head_elem_count_o = count_mem[rd_ptr_q];
  assign head_sign_o       = conv_is_sext(head_conv);
  assign head_slice_shift_o = head_shift;
  // Elements per beat is 64 / (eew * k)
  assign head_beat_elems_o = 8'd8 >> head_width_log2;

  // Widen unit only pops a command that is present
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_pop_i |-> head_valid_o)
    else $error("command popped from an empty FIFO");

  // Widened element must fit in one 64-bit word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> ({1'b0, cmd_eew_i} + {1'b0, conv_log2_factor(cmd_conv_i)}) <= 3'd3)
    else $error("command widens beyond 64 bits");

endmodule

// File: design/opq_operand_buffer.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Each word is announced by operand_issued_i one cycle before it arrives.
// Credits cover announced words, so an arriving word always finds room
//////////////////////////////////////////////////////////////////////
module opq_operand_buffer
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
#(
  parameter int unsigned DataBufDepth = default_data_depth
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Register file side
  input  word_t operand_i,
  input  logic  operand_valid_i,
  input  logic  operand_issued_i,
  output logic  operand_queue_ready_o,
  // Head word towards the widen unit
  input  logic  word_pop_i,
  output word_t head_word_o,
  output logic  head_valid_o
);

  localparam int unsigned IdxWidth = (DataBufDepth > 1) ? $clog2(DataBufDepth) : 1;

  word_t mem [DataBufDepth];

  logic [IdxWidth-1:0] wr_ptr_q;
  logic [IdxWidth-1:0] rd_ptr_q;
  logic [IdxWidth:0]   fill_q;
  logic [IdxWidth:0]   credit_d;
  logic [IdxWidth:0]   credit_q;

  function automatic logic [IdxWidth-1:0] ptr_inc(logic [IdxWidth-1:0] ptr);
    return (ptr == IdxWidth'(DataBufDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_valid_o = (fill_q != '0);
  assign head_word_o  = mem[rd_ptr_q];

  // Word storage
  always_ff @(posedge clk_i) begin
    if (operand_valid_i) begin
      mem[wr_ptr_q] <= operand_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (operand_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (word_pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (operand_valid_i && !word_pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (word_pop_i && !operand_valid_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credit counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    credit_d = credit_q;
    // Announced word takes a slot
    if (operand_issued_i) begin
      credit_d = credit_d + 1'b1;
    end
    // Slot is given back once the word leaves
    if (word_pop_i) begin
      credit_d = credit_d - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  assign operand_queue_ready_o = (credit_q < DataBufDepth);

  // A word the credits allowed never meets a full FIFO
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_i |-> fill_q < DataBufDepth)
    else $error("operand word arrived at a full FIFO");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_pop_i |-> head_valid_o)
    else $error("operand word popped from an empty FIFO");

endmodule

// File: design/opq_widen_unit.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Output is combinational from both heads. Slice and element counters
// only advance on a transferred beat and restart at each new command
//////////////////////////////////////////////////////////////////////
module opq_widen_unit
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Decoded head command
  input  logic        head_valid_i,
  input  eew_e        head_eew_i,
  input  logic        head_sign_i,
  input  logic [1:0]  head_slice_shift_i,
  input  logic [7:0]  head_beat_elems_i,
  input  elem_count_t head_elem_count_i,
  output logic        cmd_pop_o,
  // Head operand word
  input  word_t       head_word_i,
  input  logic        head_word_valid_i,
  output logic        word_pop_o,
  // Functional unit side
  output word_t       operand_o,
  output logic        operand_valid_o,
  input  logic        operand_ready_i
);

  localparam int unsigned CntWidth = elem_count_width + 1;

  logic [2:0]          slice_d;
  logic [2:0]          slice_q;
  logic [2:0]          slice_max;
  logic [5:0]          slice_offset;
  elem_count_t         elem_cnt_d;
  elem_count_t         elem_cnt_q;
  logic [CntWidth-1:0] elem_next;
  word_t               src;
  logic                beat_fire;
  logic                slice_last;
  logic                cmd_done;

  //////////////////////////////////////////////////////////////////////
  // Beat construction
  //////////////////////////////////////////////////////////////////////

  // Slice j starts at bit j * 64 / k
  assign slice_max    = 3'((4'd1 << head_slice_shift_i) - 4'd1);
  assign slice_offset = 6'({3'b0, slice_q} << (3'd6 - {1'b0, head_slice_shift_i}));
  assign src          = head_word_i >> slice_offset;

  always_comb begin
    operand_o = head_word_i;
    case ({head_eew_i, head_slice_shift_i})
      {EW8, 2'd1}: begin
        for (int e = 0; e < 4; e++) begin
          operand_o[16*e +: 16] = {{8{head_sign_i & src[8*e+7]}}, src[8*e +: 8]};
        end
      end
      {EW16, 2'd1}: begin
        for (int e = 0; e < 2; e++) begin
          operand_o[32*e +: 32] = {{16{head_sign_i & src[16*e+15]}}, src[16*e +: 16]};
        end
      end
      {EW32, 2'd1}: begin
        operand_o = {{32{head_sign_i & src[31]}}, src[31:0]};
      end
      {EW8, 2'd2}: begin
        for (int e = 0; e < 2; e++) begin
          operand_o[32*e +: 32] = {{24{head_sign_i & src[8*e+7]}}, src[8*e +: 8]};
        end
      end
      {EW16, 2'd2}: begin
        operand_o = {{48{head_sign_i & src[15]}}, src[15:0]};
      end
      {EW8, 2'd3}: begin
        operand_o = {{56{head_sign_i & src[7]}}, src[7:0]};
      end
      // No conversion passes the word through
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Beat and element accounting
  //////////////////////////////////////////////////////////////////////

  assign operand_valid_o = head_valid_i && head_word_valid_i;
  assign beat_fire       = operand_valid_o && operand_ready_i;
  assign elem_next       = {1'b0, elem_cnt_q} + CntWidth'(head_beat_elems_i);
  assign cmd_done        = (elem_next >= {1'b0, head_elem_count_i});
  assign slice_last      = (slice_q == slice_max);

  // Word leaves after its k-th slice or at the end of the command
  assign word_pop_o = beat_fire && (slice_last || cmd_done);
  assign cmd_pop_o  = beat_fire && cmd_done;

  always_comb begin
    slice_d    = slice_q;
    elem_cnt_d = elem_cnt_q;
    if (beat_fire) begin
      if (cmd_done) begin
        slice_d    = '0;
        elem_cnt_d = '0;
      end else begin
        elem_cnt_d = elem_next[elem_count_width-1:0];
        slice_d    = slice_last ? 3'd0 : slice_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slice_q    <= '0;
      elem_cnt_q <= '0;
    end else begin
      slice_q    <= slice_d;
      elem_cnt_q <= elem_cnt_d;
    end
  end

  // Stalled beat holds until taken, so neither buffer may pop under it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_valid_o && !operand_ready_i |=> operand_valid_o && $stable(operand_o))
    else $error("output beat changed while stalled");

endmodule

// File: design/opq_top.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Single consumer only. Operand words use the credit handshake
//////////////////////////////////////////////////////////////////////
module opq_top
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
#(
  parameter int unsigned CmdBufDepth  = default_cmd_depth,
  parameter int unsigned DataBufDepth = default_data_depth
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Command input
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  eew_e        cmd_eew_i,
  input  conv_e       cmd_conv_i,
  input  elem_count_t cmd_elem_count_i,
  // Register file operands
  input  word_t       operand_i,
  input  logic        operand_valid_i,
  input  logic        operand_issued_i,
  output logic        operand_queue_ready_o,
  // Functional unit output
  output word_t       operand_o,
  output logic        operand_valid_o,
  input  logic        operand_ready_i
);

  logic        cmd_head_valid;
  eew_e        cmd_head_eew;
  logic        cmd_head_sign;
  logic [1:0]  cmd_head_slice_shift;
  logic [7:0]  cmd_head_beat_elems;
  elem_count_t cmd_head_elem_count;
  logic        cmd_pop;
  word_t       word_head;
  logic        word_head_valid;
  logic        word_pop;

  opq_cmd_buffer #(
    .CmdBufDepth(CmdBufDepth)
  ) u_cmd_buffer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cmd_valid_i       (cmd_valid_i),
    .cmd_ready_o       (cmd_ready_o),
    .cmd_eew_i         (cmd_eew_i),
    .cmd_conv_i        (cmd_conv_i),
    .cmd_elem_count_i  (cmd_elem_count_i),
    .cmd_pop_i         (cmd_pop),
    .head_valid_o      (cmd_head_valid),
    .head_eew_o        (cmd_head_eew),
    .head_sign_o       (cmd_head_sign),
    .head_slice_shift_o(cmd_head_slice_shift),
    .head_beat_elems_o (cmd_head_beat_elems),
    .head_elem_count_o (cmd_head_elem_count)
  );

  opq_operand_buffer #(
    .DataBufDepth(DataBufDepth)
  ) u_operand_buffer (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .operand_i            (operand_i),
    .operand_valid_i      (operand_valid_i),
    .operand_issued_i     (operand_issued_i),
    .operand_queue_ready_o(operand_queue_ready_o),
    .word_pop_i           (word_pop),
    .head_word_o          (word_head),
    .head_valid_o         (word_head_valid)
  );

  opq_widen_unit u_widen_unit (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .head_valid_i      (cmd_head_valid),
    .head_eew_i        (cmd_head_eew),
    .head_sign_i       (cmd_head_sign),
    .head_slice_shift_i(cmd_head_slice_shift),
    .head_beat_elems_i (cmd_head_beat_elems),
    .head_elem_count_i (cmd_head_elem_count),
    .cmd_pop_o         (cmd_pop),
    .head_word_i       (word_head),
    .head_word_valid_i (word_head_valid),
    .word_pop_o        (word_pop),
    .operand_o         (operand_o),
    .operand_valid_o   (operand_valid_o),
    .operand_ready_i   (operand_ready_i)
  );

endmodule

// File: verification/opq_checker.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Predicts every output beat from the commands and words seen at the
// inputs. All sampling is on the falling edge, where signals are settled
//////////////////////////////////////////////////////////////////////
module opq_checker
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
#(
  parameter int unsigned CmdBufDepth  = default_cmd_depth,
  parameter int unsigned DataBufDepth = default_data_depth
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cmd_valid_i,
  input  logic        cmd_ready_i,
  input  eew_e        cmd_eew_i,
  input  conv_e       cmd_conv_i,
  input  elem_count_t cmd_count_i,
  input  word_t       operand_i,
  input  logic        operand_valid_i,
  input  logic        operand_issued_i,
  input  logic        queue_ready_i,
  input  word_t       result_i,
  input  logic        result_valid_i,
  input  logic        result_ready_i,
  output int unsigned tests_o,
  output int unsigned errors_o
);

  eew_e        cq_eew   [$];
  conv_e       cq_conv  [$];
  elem_count_t cq_count [$];
  word_t       wq       [$];
  int          credits;
  int unsigned slice;
  int unsigned elems;
  int unsigned test_errs;
  logic        stalled;
  word_t       stalled_data;

  function automatic int unsigned factor_log2(conv_e conv);
    return (conv == CONV_NONE) ? 0 : ((int'(conv) - 1) % 3) + 1;
  endfunction

  // Slice j of the word, each source element extended to eew*k bits
  function automatic word_t widen_slice(word_t w, eew_e eew, conv_e conv, int unsigned j);
    int unsigned sw;
    int unsigned dw;
    int unsigned n;
    int unsigned base;
    logic        sext;
    word_t       res;
    sw   = 8 << int'(eew);
    dw   = sw << factor_log2(conv);
    n    = 64 / dw;
    sext = (int'(conv) >= 1) && (int'(conv) <= 3);
    res  = '0;
    for (int i = 0; i < n; i++) begin
      base = (j * n + i) * sw;
      for (int b = 0; b < dw; b++) begin
        res[i*dw+b] = (b < sw) ? w[base+b] : (sext & w[base+sw-1]);
      end
    end
    return res;
  endfunction

  task automatic fail(string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    errors_o++;
    test_errs++;
  endtask

  task automatic take_beat();
    int unsigned lk;
    word_t       expected;
    eew_e        e;
    conv_e       c;
    e        = cq_eew[0];
    c        = cq_conv[0];
    lk       = factor_log2(c);
    expected = widen_slice(wq[0], e, c, slice);
    if (result_i !== expected) begin
      fail($sformatf("test %0d slice %0d: got %h, expected %h",
                     tests_o, slice, result_i, expected));
    end
    elems += 64 / ((8 << int'(e)) << lk);
    slice++;
    if (elems >= cq_count[0]) begin
      $display("test %0d %s %s count %0d: %s", tests_o, e.name(), c.name(),
               cq_count[0], (test_errs == 0) ? "ok" : "failed");
      void'(cq_eew.pop_front());
      void'(cq_conv.pop_front());
      void'(cq_count.pop_front());
      void'(wq.pop_front());
      credits--;
      slice     = 0;
      elems     = 0;
      test_errs = 0;
      tests_o++;
    end else if (slice == (1 << lk)) begin
      void'(wq.pop_front());
      credits--;
      slice = 0;
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      cq_eew.delete();
      cq_conv.delete();
      cq_count.delete();
      wq.delete();
      credits   = 0;
      slice     = 0;
      elems     = 0;
      test_errs = 0;
      stalled   = 1'b0;
      tests_o   = 0;
      errors_o  = 0;
    end else begin
      // Handshake flags follow the fill of both buffers
      if (cmd_ready_i !== (cq_eew.size() < CmdBufDepth)) begin
        fail("cmd_ready_o does not match command buffer fill");
      end
      if (queue_ready_i !== (credits < DataBufDepth)) begin
        fail("operand_queue_ready_o does not match outstanding credits");
      end
      if (result_valid_i !== (cq_eew.size() > 0 && wq.size() > 0)) begin
        fail("operand_valid_o does not match buffered commands and words");
      end
      if (stalled && (!result_valid_i || result_i !== stalled_data)) begin
        fail("stalled beat changed before it was taken");
      end
      stalled      = result_valid_i && !result_ready_i;
      stalled_data = result_i;
      if (result_valid_i && result_ready_i && cq_eew.size() > 0 && wq.size() > 0) begin
        take_beat();
      end
      // New entries reach the heads only after the coming edge
      if (cmd_valid_i && cmd_ready_i) begin
        cq_eew.push_back(cmd_eew_i);
        cq_conv.push_back(cmd_conv_i);
        cq_count.push_back(cmd_count_i);
      end
      if (operand_issued_i) begin
        credits++;
      end
      if (operand_valid_i) begin
        wq.push_back(operand_i);
      end
    end
  end

endmodule

// File: verification/opq_tb.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Random legal commands with matching operand words, an initial long
// stall on the output, then random back-pressure
//////////////////////////////////////////////////////////////////////
module opq_tb
  import opq_elem_pkg::*;
  import opq_cmd_pkg::*;
();

  localparam int unsigned CmdBufDepth  = default_cmd_depth;
  localparam int unsigned DataBufDepth = default_data_depth;
  localparam int unsigned NumCmds      = 64;
  localparam int unsigned StallCycles  = 40;
  localparam int unsigned ClkPeriod    = 100;
  localparam int unsigned DriveDelay   = 10;

  logic        clk_i;
  logic        rst_ni;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  eew_e        cmd_eew_i;
  conv_e       cmd_conv_i;
  elem_count_t cmd_elem_count_i;
  word_t       operand_i;
  logic        operand_valid_i;
  logic        operand_issued_i;
  logic        operand_queue_ready_o;
  word_t       operand_o;
  logic        operand_valid_o;
  logic        operand_ready_i;
  int unsigned tests_done;
  int unsigned errors;

  eew_e        gen_eew   [NumCmds];
  conv_e       gen_conv  [NumCmds];
  elem_count_t gen_count [NumCmds];
  int unsigned words_total;

  opq_top #(
    .CmdBufDepth (CmdBufDepth),
    .DataBufDepth(DataBufDepth)
  ) u_dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmd_valid_i          (cmd_valid_i),
    .cmd_ready_o          (cmd_ready_o),
    .cmd_eew_i            (cmd_eew_i),
    .cmd_conv_i           (cmd_conv_i),
    .cmd_elem_count_i     (cmd_elem_count_i),
    .operand_i            (operand_i),
    .operand_valid_i      (operand_valid_i),
    .operand_issued_i     (operand_issued_i),
    .operand_queue_ready_o(operand_queue_ready_o),
    .operand_o            (operand_o),
    .operand_valid_o      (operand_valid_o),
    .operand_ready_i      (operand_ready_i)
  );

  opq_checker #(
    .CmdBufDepth (CmdBufDepth),
    .DataBufDepth(DataBufDepth)
  ) u_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_i     (cmd_ready_o),
    .cmd_eew_i       (cmd_eew_i),
    .cmd_conv_i      (cmd_conv_i),
    .cmd_count_i     (cmd_elem_count_i),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_issued_i(operand_issued_i),
    .queue_ready_i   (operand_queue_ready_o),
    .result_i        (operand_o),
    .result_valid_i  (operand_valid_o),
    .result_ready_i  (operand_ready_i),
    .tests_o         (tests_done),
    .errors_o        (errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic int unsigned factor_log2(conv_e conv);
    return (conv == CONV_NONE) ? 0 : ((int'(conv) - 1) % 3) + 1;
  endfunction

  // Words consumed is ceil(beats / k), beats being ceil(count / elements per beat)
  function automatic int unsigned words_for_cmd(eew_e eew, conv_e conv, elem_count_t count);
    int unsigned lk;
    int unsigned epb;
    int unsigned beats;
    lk    = factor_log2(conv);
    epb   = 8 >> (int'(eew) + lk);
    beats = (count + epb - 1) / epb;
    return (beats + (1 << lk) - 1) >> lk;
  endfunction

  task automatic next_drive();
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  task automatic send_commands();
    logic accepted;
    for (int i = 0; i < NumCmds; i++) begin
      if ($urandom % 4 == 0) begin
        next_drive();
      end
      cmd_valid_i      = 1'b1;
      cmd_eew_i        = gen_eew[i];
      cmd_conv_i       = gen_conv[i];
      cmd_elem_count_i = gen_count[i];
      do begin
        @(negedge clk_i);
        accepted = cmd_ready_o;
        next_drive();
      end while (!accepted);
      cmd_valid_i = 1'b0;
    end
  endtask

  // Each word is announced by credit and follows one cycle later
  task automatic send_operands();
    int unsigned announced;
    logic        pending;
    announced = 0;
    pending   = 1'b0;
    forever begin
      next_drive();
      operand_valid_i  = pending;
      operand_i        = pending ? {$urandom, $urandom} : '0;
      pending          = 1'b0;
      operand_issued_i = 1'b0;
      if (announced < words_total && operand_queue_ready_o && ($urandom % 10) < 8) begin
        operand_issued_i = 1'b1;
        pending          = 1'b1;
        announced++;
      end
    end
  endtask

  task automatic drive_ready();
    repeat (StallCycles) next_drive();
    forever begin
      next_drive();
      operand_ready_i = (($urandom % 10) < 7);
    end
  endtask

  initial begin
    int unsigned lk;
    void'($urandom(59273));
    rst_ni           = 1'b0;
    cmd_valid_i      = 1'b0;
    cmd_eew_i        = EW8;
    cmd_conv_i       = CONV_NONE;
    cmd_elem_count_i = '0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = 1'b0;
    words_total      = 0;
    for (int i = 0; i < NumCmds; i++) begin
      gen_conv[i]  = conv_e'($urandom % 7);
      lk           = factor_log2(gen_conv[i]);
      gen_eew[i]   = eew_e'($urandom % (4 - lk));
      gen_count[i] = elem_count_t'($urandom % 40 + 1);
      words_total += words_for_cmd(gen_eew[i], gen_conv[i], gen_count[i]);
    end
    repeat (5) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;
    fork
      send_commands();
      send_operands();
      drive_ready();
    join_none
    wait (tests_done == NumCmds);
    repeat (4) @(posedge clk_i);
    $display("Finished %0d of %0d tests, %0d errors", tests_done, NumCmds, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog allows 400 cycles for each command
  initial begin
    #(400 * NumCmds * ClkPeriod);
    $display("Timeout: the run stopped after %0d of %0d tests", tests_done, NumCmds);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: list.f
design/opq_elem_pkg.sv
design/opq_cmd_pkg.sv
design/opq_cmd_buffer.sv
design/opq_operand_buffer.sv
design/opq_widen_unit.sv
design/opq_top.sv
verification/opq_checker.sv
verification/opq_tb.sv
